// ==== misc_regs.sv ====
// slave 0 misc register bank
// leds, clock generator control/status, test register and compat word
`timescale 1ns/100ps
`include "u1e_ctrl_defs.svh"

module misc_regs
   import u1e_ctrl_pkg::*;
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   input  wb_req_t    req_i,
   output wb_rsp_t    rsp_o,

   input  logic       cgen_st_status_i,
   input  logic       cgen_st_ld_i,
   input  logic       cgen_st_refmon_i,
   output logic       cgen_sync_b_o,
   output logic       cgen_ref_sel_o,
   output logic [1:0] debug_led_o
);

   logic [`U1E_DW-1:0] leds_r;
   logic [`U1E_DW-1:0] cgen_ctrl_r;
   logic [`U1E_DW-1:0] test_r;
   logic [6:0]         offset;
   logic               wr_en;

   assign offset = req_i.adr[6:0];
   assign rsp_o.ack = req_i.cyc & req_i.stb;   // zero wait state
   assign wr_en = rsp_o.ack & req_i.we;

   ////////////////////////////////////////
   // writes
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         leds_r      <= '0;
         cgen_ctrl_r <= 16'(`U1E_CGEN_CTRL_RESET);
         test_r      <= '0;
      end
      else if (wr_en)
      begin
         case (offset)
            7'(`U1E_REG_LEDS):      leds_r      <= req_i.dat;
            7'(`U1E_REG_CGEN_CTRL): cgen_ctrl_r <= req_i.dat;
            7'(`U1E_REG_TEST):      test_r      <= req_i.dat;
            default:                ;   // read-only or unused
         endcase
      end
   end

   ////////////////////////////////////////
   // reads
   always_comb
   begin
      case (offset)
         7'(`U1E_REG_LEDS):      rsp_o.dat = leds_r;
         7'(`U1E_REG_SWITCHES):  rsp_o.dat = '0;   // no switches fitted
         7'(`U1E_REG_CGEN_CTRL): rsp_o.dat = cgen_ctrl_r;
         7'(`U1E_REG_CGEN_ST):
            rsp_o.dat = {13'd0, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
         7'(`U1E_REG_TEST):      rsp_o.dat = test_r;
         7'(`U1E_REG_COMPAT):    rsp_o.dat = {8'(`U1E_WHOAMI), 8'(`U1E_COMPAT_NUM)};
         default:                rsp_o.dat = `U1E_READ_DEFAULT;
      endcase
   end

   // leds are active low on the board
   assign debug_led_o    = ~leds_r[1:0];
   assign cgen_sync_b_o  = cgen_ctrl_r[1];
   assign cgen_ref_sel_o = cgen_ctrl_r[0];

endmodule

// ==== readback_mux_32.sv ====
// slave 7 readback port
// eight 32-bit words read as 16-bit halves, low half first latches the high half
`timescale 1ns/100ps
`include "u1e_ctrl_defs.svh"

module readback_mux_32
   import u1e_ctrl_pkg::*;
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   input  wb_req_t    req_i,
   output wb_rsp_t    rsp_o,
   input  set_bus_t   set_i,
   input  vita_time_t vita_time_i,
   input  vita_time_t vita_time_pps_i
);

   logic [31:0]        test32_r;
   logic [31:0]        word;
   logic [`U1E_DW-1:0] hi_latch;   // upper half of the last word read
   logic               rd_lo;

   // test setting, readable as word 4
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         test32_r <= '0;
      else if (set_i.stb && set_i.addr == 6'(`U1E_SR_REG_TEST32))
         test32_r <= set_i.data;
   end

   always_comb
   begin
      case (req_i.adr[4:2])
         3'd0:    word = vita_time_i.hi;
         3'd1:    word = vita_time_i.lo;
         3'd2:    word = vita_time_pps_i.hi;
         3'd3:    word = vita_time_pps_i.lo;
         3'd4:    word = test32_r;
         default: word = '0;
      endcase
   end

   assign rsp_o.ack = req_i.cyc & req_i.stb;
   assign rd_lo = rsp_o.ack & ~req_i.we & ~req_i.adr[1];

   // keeps both halves of a moving word coherent
   always_ff @(posedge wb_clk)
   begin
      if (rd_lo)
         hi_latch <= word[31:16];
   end

   assign rsp_o.dat = req_i.adr[1] ? hi_latch : word[15:0];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the u1e control plane testbench with Verilator
# exit status is 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_u1e_ctrl_sim

verilator --binary --timing --assert \
   --top-module tb_u1e_ctrl \
   -f u1e_ctrl.f \
   -o "$BIN"
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Test OK$" "$LOG"; then
   exit 0
else
   echo "pass line not found in $LOG"
   exit 1
fi

// ==== settings_bus_16le.sv ====
// settings bus bridge, slaves 8 and 9
// pairs little-endian 16-bit writes into one 32-bit setting strobe
`timescale 1ns/100ps
`include "u1e_ctrl_defs.svh"

module settings_bus_16le
   import u1e_ctrl_pkg::*;
(
   input  logic     wb_clk,
   input  logic     wb_rst,
   input  wb_req_t  req_i,
   output wb_rsp_t  rsp_o,
   output set_bus_t set_o
);

   localparam logic [1:0] ST_IDLE     = 2'd0;
   localparam logic [1:0] ST_LOW_HELD = 2'd1;
   localparam logic [1:0] ST_STROBE   = 2'd2;

   logic [1:0]             state_r;
   logic [`U1E_DW-1:0]     low_r;     // last lower half written
   logic [`U1E_SET_AW-1:0] addr_r;
   logic [31:0]            data_r;
   logic                   wr_lo;
   logic                   wr_hi;

   assign rsp_o.ack = req_i.cyc & req_i.stb;
   assign rsp_o.dat = '0;   // write only

   assign wr_lo = rsp_o.ack & req_i.we & ~req_i.adr[1];
   assign wr_hi = rsp_o.ack & req_i.we & req_i.adr[1];

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         state_r <= ST_IDLE;
      else
      begin
         case (state_r)
            ST_IDLE, ST_LOW_HELD:
               if (wr_hi)
                  state_r <= ST_STROBE;   // idle upper write reuses old low half
               else if (wr_lo)
                  state_r <= ST_LOW_HELD;
            ST_STROBE:
               if (wr_hi)
                  state_r <= ST_STROBE;
               else if (wr_lo)
                  state_r <= ST_LOW_HELD;
               else
                  state_r <= ST_IDLE;
            default: state_r <= ST_IDLE;
         endcase
      end
   end

   // payload capture
   always_ff @(posedge wb_clk)
   begin
      if (wr_lo)
         low_r <= req_i.dat;
      if (wr_hi)
      begin
         addr_r <= req_i.adr[`U1E_SET_AW+1:2];   // word address
         data_r <= {req_i.dat, low_r};
      end
   end

   assign set_o.stb  = (state_r == ST_STROBE);
   assign set_o.addr = addr_r;
   assign set_o.data = data_r;

endmodule

// ==== tb_u1e_ctrl.sv ====
// u1e control plane testbench
// drives the wishbone master and checks misc bank, settings, readback, vita time and pps
`timescale 1ns/100ps
`include "u1e_ctrl_defs.svh"

module tb_u1e_ctrl
   import u1e_ctrl_pkg::*;
();

   localparam logic [10:0] RB_BASE  = 11'(`U1E_SLAVE_READBACK << `U1E_DECODE_LSB);
   localparam logic [10:0] SET_BASE = 11'(`U1E_SLAVE_SETTINGS << `U1E_DECODE_LSB);

   logic       wb_clk;
   logic       wb_rst;
   wb_req_t    wb_req;
   wb_rsp_t    wb_rsp;
   logic       pps;
   logic       cgen_st_status;
   logic       cgen_st_ld;
   logic       cgen_st_refmon;
   logic       cgen_sync_b;
   logic       cgen_ref_sel;
   logic [1:0] debug_led;
   int         checks;
   int         errors;

   u1e_ctrl_core u1e_ctrl_core_inst
   (
      .wb_clk           (wb_clk),
      .wb_rst           (wb_rst),
      .wb_req_i         (wb_req),
      .wb_rsp_o         (wb_rsp),
      .pps_i            (pps),
      .cgen_st_status_i (cgen_st_status),
      .cgen_st_ld_i     (cgen_st_ld),
      .cgen_st_refmon_i (cgen_st_refmon),
      .cgen_sync_b_o    (cgen_sync_b),
      .cgen_ref_sel_o   (cgen_ref_sel),
      .debug_led_o      (debug_led)
   );

   initial
   begin
      wb_clk = 1'b0;
      forever #4 wb_clk = ~wb_clk;
   end

   ////////////////////////////////////////
   // address helpers
   function automatic logic [10:0] setting_adr(input logic [5:0] addr, input logic upper);
      return SET_BASE | {3'b000, addr, upper, 1'b0};   // adr[7:2] is the setting
   endfunction

   function automatic logic [10:0] readback_adr(input logic [2:0] idx, input logic upper);
      return RB_BASE | {6'd0, idx, upper, 1'b0};
   endfunction

   ////////////////////////////////////////
   // checks
   task automatic check_equal(input string name, input logic [63:0] got,
                              input logic [63:0] expected);
      checks++;
      assert (got == expected)
      else
      begin
         $display("Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, got);
         errors++;
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      checks++;
      assert (cond)
      else
      begin
         $display("Failure at %0t: %s did not hold", $time, what);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int err_start);
      $display("test %s: %s", name, (errors == err_start) ? "passed" : "failed");
   endtask

   ////////////////////////////////////////
   // bus tasks entered 1 ns after a rising edge
   task automatic wb_cycle(input logic [10:0] adr, input logic [15:0] dat_w, input logic we,
                           output logic [15:0] dat_r, output logic acked);
      int waited;
      waited = 0;
      wb_req.adr = adr;
      wb_req.dat = dat_w;
      wb_req.sel = 2'b11;
      wb_req.we  = we;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      #5;   // mid cycle where ack and data have settled
      while (!wb_rsp.ack && waited < 50)
      begin
         @(posedge wb_clk);
         #6;
         waited++;
      end
      acked = wb_rsp.ack;
      dat_r = wb_rsp.dat;
      if (!acked)
         $display("Timeout at %0t: no ack from address 0x%03h after 50 cycles", $time, adr);
      @(posedge wb_clk);   // transfer completes on this edge
      #1;
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      wb_req.we  = 1'b0;
   endtask

   task automatic wb_write(input logic [10:0] adr, input logic [15:0] dat);
      logic [15:0] unused_dat;
      logic        acked;
      wb_cycle(adr, dat, 1'b1, unused_dat, acked);
      check_true(acked, "write acknowledge");
      @(posedge wb_clk);   // idle cycle lets a setting strobe land
      #1;
   endtask

   task automatic wb_read(input logic [10:0] adr, output logic [15:0] dat,
                          output logic acked);
      wb_cycle(adr, 16'h0000, 1'b0, dat, acked);
   endtask

   task automatic read_check(input logic [10:0] adr, input string name,
                             input logic [15:0] expected);
      logic [15:0] dat;
      logic        acked;
      wb_read(adr, dat, acked);
      check_true(acked, "read acknowledge");
      check_equal(name, 64'(dat), 64'(expected));
   endtask

   task automatic read_word(input logic [2:0] idx, output logic [31:0] word);
      logic [15:0] lo;
      logic [15:0] hi;
      logic        ok_lo;
      logic        ok_hi;
      wb_read(readback_adr(idx, 1'b0), lo, ok_lo);   // latches the upper half
      wb_read(readback_adr(idx, 1'b1), hi, ok_hi);
      check_true(ok_lo && ok_hi, "readback acknowledge");
      word = {hi, lo};
   endtask

   task automatic write_setting(input logic [5:0] addr, input logic [31:0] data);
      wb_write(setting_adr(addr, 1'b0), data[15:0]);
      wb_write(setting_adr(addr, 1'b1), data[31:16]);
   endtask

   task automatic read_time(input logic [2:0] hi_idx, output logic [63:0] t);
      logic [31:0] lo;
      logic [31:0] hi;
      read_word(hi_idx + 3'd1, lo);   // low word first
      read_word(hi_idx, hi);
      t = {hi, lo};
   endtask

   ////////////////////////////////////////
   // test sequence
   initial
   begin
      logic [15:0] rd;
      logic        ok;
      logic [15:0] v_leds;
      logic [15:0] v_ctrl;
      logic [15:0] v_test;
      logic [1:0]  exp_led;
      logic [2:0]  st;
      logic [31:0] w32;
      logic [31:0] rd32;
      logic [63:0] t_load;
      logic [63:0] t1;
      logic [63:0] t2;
      logic [63:0] tp;
      int          start;
      void'($urandom(96));
      checks = 0;
      errors = 0;
      wb_rst = 1'b1;
      wb_req = '0;
      pps = 1'b0;
      cgen_st_status = 1'b0;
      cgen_st_ld = 1'b0;
      cgen_st_refmon = 1'b0;
      repeat (4) @(posedge wb_clk);
      #1;
      wb_rst = 1'b0;

      start = errors;
      read_check(11'(`U1E_REG_LEDS), "leds", 16'h0000);
      read_check(11'(`U1E_REG_CGEN_CTRL), "cgen_ctrl", 16'h0003);
      check_equal("cgen_sync_b_o", 64'(cgen_sync_b), 64'd1);
      check_equal("cgen_ref_sel_o", 64'(cgen_ref_sel), 64'd1);
      v_leds = 16'($urandom);
      v_ctrl = 16'($urandom);
      v_test = 16'($urandom);
      wb_write(11'(`U1E_REG_LEDS), v_leds);
      wb_write(11'(`U1E_REG_CGEN_CTRL), v_ctrl);
      wb_write(11'(`U1E_REG_TEST), v_test);
      read_check(11'(`U1E_REG_LEDS), "leds", v_leds);
      read_check(11'(`U1E_REG_CGEN_CTRL), "cgen_ctrl", v_ctrl);
      read_check(11'(`U1E_REG_TEST), "test", v_test);
      exp_led = ~v_leds[1:0];   // leds drive low
      check_equal("debug_led_o", 64'(debug_led), 64'(exp_led));
      check_equal("cgen_sync_b_o", 64'(cgen_sync_b), 64'(v_ctrl[1]));
      check_equal("cgen_ref_sel_o", 64'(cgen_ref_sel), 64'(v_ctrl[0]));
      report_test("misc write/readback", start);

      start = errors;
      read_check(11'(`U1E_REG_COMPAT), "compat", 16'h0003);
      read_check(11'(`U1E_REG_SWITCHES), "switches", 16'h0000);
      st = 3'($urandom);
      cgen_st_status = st[2];
      cgen_st_ld = st[1];
      cgen_st_refmon = st[0];
      read_check(11'(`U1E_REG_CGEN_ST), "cgen_st", {13'd0, st});
      cgen_st_status = ~st[2];   // every status bit seen both ways
      cgen_st_ld = ~st[1];
      cgen_st_refmon = ~st[0];
      read_check(11'(`U1E_REG_CGEN_ST), "cgen_st", {13'd0, ~st});
      read_check(11'd10, "unlisted offset", 16'hBEEF);
      report_test("fixed reads", start);

      start = errors;
      w32 = $urandom;
      write_setting(6'(`U1E_SR_REG_TEST32), w32);
      write_setting(6'd0, ~w32);   // setting 0 sits on slave 8
      read_word(3'd4, rd32);
      check_equal("test32", 64'(rd32), 64'(w32));
      report_test("settings path", start);

      start = errors;
      t_load = {32'($urandom), 1'b0, 31'($urandom)};   // no carry out of the low word
      write_setting(6'(`U1E_SR_TIME64), t_load[63:32]);
      write_setting(6'(`U1E_SR_TIME64 + 1), t_load[31:0]);
      read_time(3'd0, t1);
      read_time(3'd0, t2);
      check_true(t1 >= t_load && t1 - t_load < 300, "first time read near loaded value");
      check_true(t2 >= t_load && t2 - t_load < 300, "second time read near loaded value");
      check_true(t2 > t1, "time advancing between reads");
      report_test("time load and count", start);

      start = errors;
      read_time(3'd0, t1);
      pps = 1'b1;
      repeat (6) @(posedge wb_clk);
      #1;
      pps = 1'b0;
      read_time(3'd0, t2);
      read_time(3'd2, tp);
      check_true(t1 < tp && tp < t2, "pps time between surrounding time reads");
      report_test("pps capture", start);

      start = errors;
      wb_read(11'(5 << `U1E_DECODE_LSB), rd, ok);   // timeout expected here
      check_true(!ok, "no ack from unmapped slave 5");
      report_test("unmapped slave", start);

      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

// ==== u1e_ctrl.f ====
+incdir+.
u1e_ctrl_pkg.sv
wb_slave_decode.sv
misc_regs.sv
settings_bus_16le.sv
vita_time_64.sv
readback_mux_32.sv
u1e_ctrl_core.sv
tb_u1e_ctrl.sv

// ==== u1e_ctrl_core.sv ====
// u1e control plane top
// wishbone decode, misc bank, settings bus, readback port and vita time
`timescale 1ns/100ps
`include "u1e_ctrl_defs.svh"

module u1e_ctrl_core
   import u1e_ctrl_pkg::*;
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   input  wb_req_t    wb_req_i,
   output wb_rsp_t    wb_rsp_o,
   input  logic       pps_i,

   input  logic       cgen_st_status_i,
   input  logic       cgen_st_ld_i,
   input  logic       cgen_st_refmon_i,
   output logic       cgen_sync_b_o,
   output logic       cgen_ref_sel_o,
   output logic [1:0] debug_led_o
);

   wb_req_t    misc_req;
   wb_req_t    rb_req;
   wb_req_t    set_req;
   wb_rsp_t    misc_rsp;
   wb_rsp_t    rb_rsp;
   wb_rsp_t    set_rsp;
   set_bus_t   set_bus;
   vita_time_t vita_time;
   vita_time_t vita_time_pps;

   ////////////////////////////////////////
   // bus fabric and slaves
   wb_slave_decode decode_inst
   (
      .wb_req_i       (wb_req_i),
      .wb_rsp_o       (wb_rsp_o),
      .misc_req_o     (misc_req),
      .readback_req_o (rb_req),
      .settings_req_o (set_req),
      .misc_rsp_i     (misc_rsp),
      .readback_rsp_i (rb_rsp),
      .settings_rsp_i (set_rsp)
   );

   misc_regs misc_regs_inst
   (
      .wb_clk           (wb_clk),
      .wb_rst           (wb_rst),
      .req_i            (misc_req),
      .rsp_o            (misc_rsp),
      .cgen_st_status_i (cgen_st_status_i),
      .cgen_st_ld_i     (cgen_st_ld_i),
      .cgen_st_refmon_i (cgen_st_refmon_i),
      .cgen_sync_b_o    (cgen_sync_b_o),
      .cgen_ref_sel_o   (cgen_ref_sel_o),
      .debug_led_o      (debug_led_o)
   );

   settings_bus_16le settings_inst
   (
      .wb_clk (wb_clk),
      .wb_rst (wb_rst),
      .req_i  (set_req),
      .rsp_o  (set_rsp),
      .set_o  (set_bus)
   );

   readback_mux_32 readback_inst
   (
      .wb_clk          (wb_clk),
      .wb_rst          (wb_rst),
      .req_i           (rb_req),
      .rsp_o           (rb_rsp),
      .set_i           (set_bus),
      .vita_time_i     (vita_time),
      .vita_time_pps_i (vita_time_pps)
   );

   ////////////////////////////////////////
   // timekeeping
   vita_time_64 vita_time_inst
   (
      .wb_clk          (wb_clk),
      .wb_rst          (wb_rst),
      .set_i           (set_bus),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps)
   );

endmodule

// ==== u1e_ctrl_defs.svh ====
// u1e control plane constants
// bus widths, slave map, misc register offsets and setting addresses
`ifndef U1E_CTRL_DEFS_SVH
`define U1E_CTRL_DEFS_SVH

// wishbone geometry
`define U1E_DW              16
`define U1E_AW              11
`define U1E_SW              2
`define U1E_DECODE_LSB      7     // slave number sits in adr[10:7]

// slave numbers
`define U1E_SLAVE_MISC      0
`define U1E_SLAVE_READBACK  7
`define U1E_SLAVE_SETTINGS  8     // 8 and 9 both land here

// misc bank, byte offsets
`define U1E_REG_LEDS        0
`define U1E_REG_SWITCHES    2
`define U1E_REG_CGEN_CTRL   4
`define U1E_REG_CGEN_ST     6
`define U1E_REG_TEST        8
`define U1E_REG_COMPAT      16

// reset and identity values
`define U1E_CGEN_CTRL_RESET 3
`define U1E_COMPAT_NUM      3
`define U1E_WHOAMI          0
`define U1E_READ_DEFAULT    16'hBEEF

// settings bus, 64 regs of 32 bits
`define U1E_SR_TIME64       40    // +0 high word, +1 low word and load
`define U1E_SR_REG_TEST32   52
`define U1E_SET_AW          6

`endif

// ==== u1e_ctrl_pkg.sv ====
// u1e control plane types
// wishbone request/response, settings write and vita time bundles
package u1e_ctrl_pkg;

   // master to slave
   typedef struct packed
   {
      logic [10:0] adr;   // byte address
      logic [15:0] dat;
      logic [1:0]  sel;
      logic        we;
      logic        cyc;
      logic        stb;
   } wb_req_t;

   // slave to master
   typedef struct packed
   {
      logic [15:0] dat;
      logic        ack;
   } wb_rsp_t;

   // one 32-bit setting write
   typedef struct packed
   {
      logic        stb;
      logic [5:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   // 64-bit vita time, high word first
   typedef struct packed
   {
      logic [31:0] hi;
      logic [31:0] lo;
   } vita_time_t;

endpackage

// ==== vita_time_64.sv ====
// 64-bit vita time counter
// loadable from the settings bus, samples the time on each pps rising edge
`timescale 1ns/100ps
`include "u1e_ctrl_defs.svh"

module vita_time_64
   import u1e_ctrl_pkg::*;
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   input  set_bus_t   set_i,
   input  logic       pps_i,
   output vita_time_t vita_time_o,
   output vita_time_t vita_time_pps_o
);

   logic [31:0] time_hi_hold;
   logic [63:0] time_cnt;
   logic [63:0] time_pps;
   logic        pps_sync;
   logic        pps_dly;
   logic        pps_edge;
   logic        set_hi;
   logic        set_lo;

   assign set_hi = set_i.stb & (set_i.addr == 6'(`U1E_SR_TIME64));
   assign set_lo = set_i.stb & (set_i.addr == 6'(`U1E_SR_TIME64 + 1));

   ////////////////////////////////////////
   // counter and load
   always_ff @(posedge wb_clk)
   begin
      if (set_hi)
         time_hi_hold <= set_i.data;   // waits for the low word
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         time_cnt <= '0;
      else if (set_lo)
         time_cnt <= {time_hi_hold, set_i.data};
      else
         time_cnt <= time_cnt + 64'd1;
   end

   ////////////////////////////////////////
   // pps sampling
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_sync <= 1'b0;
         pps_dly  <= 1'b0;
      end
      else
      begin
         pps_sync <= pps_i;      // single flop, pps is slow
         pps_dly  <= pps_sync;
      end
   end

   assign pps_edge = pps_sync & ~pps_dly;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         time_pps <= '0;
      else if (pps_edge)
         time_pps <= time_cnt;
   end

   assign vita_time_o     = time_cnt;
   assign vita_time_pps_o = time_pps;

endmodule

// ==== wb_slave_decode.sv ====
// single-master wishbone decode
// routes strobes to misc, readback and settings slaves, muxes the response back
`timescale 1ns/100ps
`include "u1e_ctrl_defs.svh"

module wb_slave_decode
   import u1e_ctrl_pkg::*;
(
   input  wb_req_t wb_req_i,
   output wb_rsp_t wb_rsp_o,

   output wb_req_t misc_req_o,
   output wb_req_t readback_req_o,
   output wb_req_t settings_req_o,

   input  wb_rsp_t misc_rsp_i,
   input  wb_rsp_t readback_rsp_i,
   input  wb_rsp_t settings_rsp_i
);

   logic [`U1E_AW-`U1E_DECODE_LSB-1:0] slave_num;
   logic                               misc_sel;
   logic                               rb_sel;
   logic                               set_sel;

   assign slave_num = wb_req_i.adr[`U1E_AW-1:`U1E_DECODE_LSB];

   assign misc_sel = (slave_num == 4'(`U1E_SLAVE_MISC));
   assign rb_sel   = (slave_num == 4'(`U1E_SLAVE_READBACK));
   // settings slave is double wide, ignore the lsb of the slave number
   assign set_sel  = (slave_num[3:1] == 3'(`U1E_SLAVE_SETTINGS >> 1));

   // everything fans out, only stb is qualified
   always_comb
   begin
      misc_req_o         = wb_req_i;
      misc_req_o.stb     = wb_req_i.stb & misc_sel;
      readback_req_o     = wb_req_i;
      readback_req_o.stb = wb_req_i.stb & rb_sel;
      settings_req_o     = wb_req_i;
      settings_req_o.stb = wb_req_i.stb & set_sel;
   end

   always_comb
   begin
      if (misc_sel)
         wb_rsp_o = misc_rsp_i;
      else if (rb_sel)
         wb_rsp_o = readback_rsp_i;
      else if (set_sel)
         wb_rsp_o = settings_rsp_i;
      else
         wb_rsp_o = '0;   // unmapped, master waits forever
   end

endmodule
